//--- sources.f
verilog/rv_isa_pkg.sv
verilog/pipe_ctrl_pkg.sv
verilog/gpr_file.sv
verilog/idu.sv
verilog/pipe_reg.sv
verilog/decode_stage.sv
testbench/tb_clk_gen.sv
testbench/decode_stage_tb.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - verilog/rv_isa_pkg.sv
  - verilog/pipe_ctrl_pkg.sv
  - verilog/gpr_file.sv
  - verilog/idu.sv
  - verilog/pipe_reg.sv
  - verilog/decode_stage.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/decode_stage_tb.sv

//--- testbench/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;

  // a zero fetch word means no fetch in that step
  typedef struct packed {
    logic [31:0]         inst;
    logic [1:0]          ftrap;
    pipe_ctrl_pkg::wb_t  wb;
    logic [31:0]         ex;
    pipe_ctrl_pkg::fwd_t fwd;
  } row_t;

  logic                  clk;
  logic                  rst_n;
  pipe_ctrl_pkg::fetch_t fetch;
  pipe_ctrl_pkg::wb_t    wb;
  logic [31:0]           ex_result;
  pipe_ctrl_pkg::fwd_t   mem_fwd;
  pipe_ctrl_pkg::id_ex_t id_ex;
  logic                  stall;

  row_t                  rows[$];
  logic [31:0]           m_regs[0:31];
  pipe_ctrl_pkg::fetch_t m_ifid;
  pipe_ctrl_pkg::id_ex_t m_idex;
  integer                seed = 20;
  int                    checks = 0;
  int                    errors = 0;
  int                    cycles = 0;
  int                    limit = 1000;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  decode_stage #(
    .IF_ID_BUBBLE ('0),
    .ID_EX_BUBBLE ('0)
  ) i_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .fetch_i     (fetch),
    .wb_i        (wb),
    .ex_result_i (ex_result),
    .mem_fwd_i   (mem_fwd),
    .id_ex_o     (id_ex),
    .stall_o     (stall)
  );

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  // expected bundle without operand data
  function automatic pipe_ctrl_pkg::id_ex_t ref_decode(input pipe_ctrl_pkg::fetch_t f);
    pipe_ctrl_pkg::id_ex_t d;
    logic [31:0]           w;
    logic [2:0]            f3;
    logic [6:0]            f7;
    logic                  ok;
    logic                  reg_op;
    logic                  alt;
    logic [2:0]            use_rs;
    d = '0;
    w = f.inst;
    f3 = w[14:12];
    f7 = w[31:25];
    ok = 1'b1;
    use_rs = 3'b000;
    if (!f.valid) return d;
    case (w[6:0])
      rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC: begin
        use_rs = 3'b001;
        d.imm = {w[31:12], 12'h000};
        d.alu_op = pipe_ctrl_pkg::ALU_ADD;
        if (w[6:0] == rv_isa_pkg::OPC_LUI) d.exc_op = pipe_ctrl_pkg::EXC_LUI;
        else d.exc_op = pipe_ctrl_pkg::EXC_AUIPC;
      end
      rv_isa_pkg::OPC_JAL: begin
        use_rs = 3'b001;
        d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        d.alu_op = pipe_ctrl_pkg::ALU_ADD;
        d.exc_op = pipe_ctrl_pkg::EXC_JAL;
      end
      rv_isa_pkg::OPC_JALR: begin
        ok = (f3 == rv_isa_pkg::F3_JALR);
        use_rs = 3'b101;
        d.imm = {{21{w[31]}}, w[30:20]};
        d.alu_op = pipe_ctrl_pkg::ALU_ADD;
        d.exc_op = pipe_ctrl_pkg::EXC_JALR;
      end
      rv_isa_pkg::OPC_BRANCH: begin
        ok = (f3[2:1] != 2'b01);
        use_rs = 3'b110;
        d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        d.exc_op = pipe_ctrl_pkg::EXC_BRANCH;
        case (f3)
          rv_isa_pkg::F3_BEQ: d.alu_op = pipe_ctrl_pkg::ALU_BEQ;
          rv_isa_pkg::F3_BNE: d.alu_op = pipe_ctrl_pkg::ALU_BNE;
          rv_isa_pkg::F3_BLT: d.alu_op = pipe_ctrl_pkg::ALU_BLT;
          rv_isa_pkg::F3_BGE: d.alu_op = pipe_ctrl_pkg::ALU_BGE;
          rv_isa_pkg::F3_BLTU: d.alu_op = pipe_ctrl_pkg::ALU_BLTU;
          default: d.alu_op = pipe_ctrl_pkg::ALU_BGEU;
        endcase
      end
      rv_isa_pkg::OPC_LOAD: begin
        // widths 3, 6 and 7 are reserved
        ok = (f3 != 3'b011) && (f3 < 3'b110);
        use_rs = 3'b101;
        d.imm = {{21{w[31]}}, w[30:20]};
        d.alu_op = pipe_ctrl_pkg::ALU_ADD;
        d.exc_op = pipe_ctrl_pkg::EXC_LOAD;
        case (f3)
          rv_isa_pkg::F3_B: d.mem_op = pipe_ctrl_pkg::MEM_LB;
          rv_isa_pkg::F3_H: d.mem_op = pipe_ctrl_pkg::MEM_LH;
          rv_isa_pkg::F3_W: d.mem_op = pipe_ctrl_pkg::MEM_LW;
          rv_isa_pkg::F3_BU: d.mem_op = pipe_ctrl_pkg::MEM_LBU;
          default: d.mem_op = pipe_ctrl_pkg::MEM_LHU;
        endcase
      end
      rv_isa_pkg::OPC_STORE: begin
        ok = (f3 <= 3'b010);
        use_rs = 3'b110;
        d.imm = {{21{w[31]}}, w[30:25], w[11:7]};
        d.alu_op = pipe_ctrl_pkg::ALU_ADD;
        d.exc_op = pipe_ctrl_pkg::EXC_STORE;
        case (f3)
          rv_isa_pkg::F3_B: d.mem_op = pipe_ctrl_pkg::MEM_SB;
          rv_isa_pkg::F3_H: d.mem_op = pipe_ctrl_pkg::MEM_SH;
          default: d.mem_op = pipe_ctrl_pkg::MEM_SW;
        endcase
      end
      rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP: begin
        reg_op = (w[6:0] == rv_isa_pkg::OPC_OP);
        alt = (f7 == rv_isa_pkg::F7_ALT);
        // funct7 only matters for register ops and shifts
        if (reg_op || f3 == rv_isa_pkg::F3_SLL || f3 == rv_isa_pkg::F3_SR) begin
          ok = (f7 == rv_isa_pkg::F7_BASE) ||
               (alt && (f3 == rv_isa_pkg::F3_SR || (reg_op && f3 == rv_isa_pkg::F3_ADD)));
        end
        use_rs = reg_op ? 3'b111 : 3'b101;
        d.imm = reg_op ? '0 : {{21{w[31]}}, w[30:20]};
        d.exc_op = reg_op ? pipe_ctrl_pkg::EXC_OPREG : pipe_ctrl_pkg::EXC_OPIMM;
        case (f3)
          rv_isa_pkg::F3_ADD: d.alu_op = (reg_op && alt) ? pipe_ctrl_pkg::ALU_SUB :
                                                           pipe_ctrl_pkg::ALU_ADD;
          rv_isa_pkg::F3_SLL: d.alu_op = pipe_ctrl_pkg::ALU_SLL;
          rv_isa_pkg::F3_SLT: d.alu_op = pipe_ctrl_pkg::ALU_SLT;
          rv_isa_pkg::F3_SLTU: d.alu_op = pipe_ctrl_pkg::ALU_SLTU;
          rv_isa_pkg::F3_XOR: d.alu_op = pipe_ctrl_pkg::ALU_XOR;
          rv_isa_pkg::F3_SR: d.alu_op = alt ? pipe_ctrl_pkg::ALU_SRA : pipe_ctrl_pkg::ALU_SRL;
          rv_isa_pkg::F3_OR: d.alu_op = pipe_ctrl_pkg::ALU_OR;
          default: d.alu_op = pipe_ctrl_pkg::ALU_AND;
        endcase
      end
      rv_isa_pkg::OPC_SYSTEM: begin
        ok = (w == rv_isa_pkg::ECALL_WORD) || (w == rv_isa_pkg::EBREAK_WORD) ||
             (w == rv_isa_pkg::MRET_WORD);
        use_rs = 3'b101;
        d.imm = {{21{w[31]}}, w[30:20]};
        if (w == rv_isa_pkg::EBREAK_WORD) d.exc_op = pipe_ctrl_pkg::EXC_EBREAK;
      end
      default: ok = 1'b0;
    endcase
    if (!ok) begin
      d = '0;
      use_rs = 3'b000;
    end
    d.valid = 1'b1;
    d.addr = f.addr;
    d.inst = w;
    d.rs1_idx = use_rs[2] ? w[19:15] : 5'd0;
    d.rs2_idx = use_rs[1] ? w[24:20] : 5'd0;
    d.rd_idx = use_rs[0] ? w[11:7] : 5'd0;
    d.trap = f.trap;
    d.trap.illegal_inst = !ok;
    d.trap.ecall = (w == rv_isa_pkg::ECALL_WORD);
    d.trap.ebreak = (w == rv_isa_pkg::EBREAK_WORD);
    d.trap.mret = (w == rv_isa_pkg::MRET_WORD);
    return d;
  endfunction

  // execute result, then memory forward, then writeback, then stored value
  function automatic logic [31:0] operand(input logic [4:0] idx);
    if (idx == 5'd0) return '0;
    if (idx == m_idex.rd_idx) return ex_result;
    if (idx == mem_fwd.addr) return mem_fwd.data;
    if (wb.we && idx == wb.addr) return wb.data;
    return m_regs[idx];
  endfunction

  // writeback idles when its data is zero
  task automatic add_row(input logic [31:0] inst, input logic [1:0] ftrap,
                         input logic [4:0] wa, input logic [31:0] wd, input logic [31:0] ex,
                         input logic [4:0] fa, input logic [31:0] fd);
    rows.push_back({inst, ftrap, (wd != '0), wa, wd, ex, fa, fd});
  endtask

  task automatic apply_row(input int idx);
    row_t r;
    r = rows[idx];
    fetch = '0;
    if (r.inst != '0) begin
      fetch.valid = 1'b1;
      fetch.addr = 32'h0000_1000 + 32'(idx) * 4;
      fetch.inst = r.inst;
      fetch.trap = {r.ftrap, 4'b0000};
    end
    wb = r.wb;
    ex_result = r.ex;
    mem_fwd = r.fwd;
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    logic [31:0] rnd2;
    add_row(32'h0, 2'b00, 5'd1, 32'h0000_0011, 32'h0, 5'd0, 32'h0);
    add_row(32'h0, 2'b00, 5'd2, 32'h0000_0022, 32'h0, 5'd0, 32'h0);
    add_row(32'h0, 2'b00, 5'd3, 32'h8000_0033, 32'h0, 5'd0, 32'h0);
    add_row(32'h0, 2'b00, 5'd0, 32'hffff_ffff, 32'h0, 5'd0, 32'h0);
    add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd5, rv_isa_pkg::OPC_OP), 2'b00,
            5'd0, 32'h0, 32'h0, 5'd0, 32'h0);
    // idle writeback aimed at x1 while the add reads it
    add_row(enc_r(7'h20, 5'd3, 5'd5, 3'd0, 5'd6, rv_isa_pkg::OPC_OP), 2'b00,
            5'd1, 32'h0, 32'h0, 5'd0, 32'h0);
    add_row(enc_i(12'hffb, 5'd1, 3'd0, 5'd7, rv_isa_pkg::OPC_OP_IMM), 2'b00,
            5'd0, 32'h0, 32'h0000_5555, 5'd0, 32'h0);
    // sw x2, -8(x7)
    add_row({7'h7f, 5'd2, 5'd7, 3'd2, 5'h18, rv_isa_pkg::OPC_STORE}, 2'b00,
            5'd0, 32'h0, 32'h0, 5'd0, 32'h0);
    // beq x1, x2, -16 while sw sees ex, mem and writeback on its operands
    add_row({1'b1, 6'h3f, 5'd2, 5'd1, 3'd0, 4'b1000, 1'b1, rv_isa_pkg::OPC_BRANCH}, 2'b00,
            5'd2, 32'h0000_2222, 32'h0000_7777, 5'd7, 32'h0000_0bad);
    add_row({20'hfffff, 5'd10, rv_isa_pkg::OPC_LUI}, 2'b00,
            5'd0, 32'h0, 32'h0000_abcd, 5'd1, 32'h1111_0000);
    // jal x1, -4
    add_row({1'b1, 10'h3fe, 1'b1, 8'hff, 5'd1, rv_isa_pkg::OPC_JAL}, 2'b00,
            5'd0, 32'h0, 32'h0, 5'd0, 32'h0);
    add_row({20'h12345, 5'd12, rv_isa_pkg::OPC_AUIPC}, 2'b00,
            5'd0, 32'h0, 32'h0, 5'd0, 32'h0);
    add_row(enc_i(12'h007, 5'd1, 3'd0, 5'd0, rv_isa_pkg::OPC_OP_IMM), 2'b00,
            5'd0, 32'h0, 32'h0, 5'd0, 32'h0);
    add_row(enc_r(7'h00, 5'd2, 5'd0, 3'd0, 5'd14, rv_isa_pkg::OPC_OP), 2'b00,
            5'd0, 32'h0, 32'h0, 5'd0, 32'h0);
    // lw x15 then a dependent add that waits for the forward
    add_row(enc_i(12'h004, 5'd1, 3'd2, 5'd15, rv_isa_pkg::OPC_LOAD), 2'b00,
            5'd0, 32'h0bad_0000, 32'h0000_eeee, 5'd0, 32'h0000_ffff);
    add_row(enc_r(7'h00, 5'd2, 5'd15, 3'd0, 5'd16, rv_isa_pkg::OPC_OP), 2'b00,
            5'd0, 32'h0, 32'h0, 5'd0, 32'h0);
    add_row(enc_i(12'h7ff, 5'd3, 3'd1, 5'd17, rv_isa_pkg::OPC_LOAD), 2'b00,
            5'd0, 32'h0, 32'h0000_9999, 5'd15, 32'h1515_1515);
    add_row(enc_i(12'h8f0, 5'd1, 3'd4, 5'd18, rv_isa_pkg::OPC_OP_IMM), 2'b00,
            5'd0, 32'h0, 32'h0, 5'd0, 32'h0);
    add_row(enc_i({7'h20, 5'd4}, 5'd3, 3'd5, 5'd19, rv_isa_pkg::OPC_OP_IMM), 2'b00,
            5'd0, 32'h0, 32'h0, 5'd0, 32'h0);
    add_row(rv_isa_pkg::ECALL_WORD, 2'b10, 5'd0, 32'h0, 32'h0, 5'd0, 32'h0);
    add_row(rv_isa_pkg::EBREAK_WORD, 2'b00, 5'd0, 32'h0, 32'h0, 5'd0, 32'h0);
    add_row(rv_isa_pkg::MRET_WORD, 2'b01, 5'd0, 32'h0, 32'h0, 5'd0, 32'h0);
    add_row(32'hffff_ffff, 2'b00, 5'd0, 32'h0, 32'h0, 5'd0, 32'h0);
    for (int i = 0; i < 4; i++) begin
      rnd = $random(seed);
      rnd2 = $random(seed);
      add_row(enc_i(rnd[31:20], rnd[19:15], rnd[14:12], rnd[11:7], rv_isa_pkg::OPC_OP_IMM),
              2'b00, rnd2[4:0], rnd2, rnd ^ rnd2, rnd2[9:5], ~rnd2);
    end
    // drain the two pipeline registers
    add_row(32'h0, 2'b00, 5'd0, 32'h0, 32'h0, 5'd0, 32'h0);
    add_row(32'h0, 2'b00, 5'd0, 32'h0, 32'h0, 5'd0, 32'h0);
  endtask

  initial begin
    pipe_ctrl_pkg::id_ex_t d;
    logic                  exp_stall;
    int                    r;
    int                    cur;
    fetch = '0;
    wb = '0;
    ex_result = '0;
    mem_fwd = '0;
    build_table();
    limit = 2 * rows.size() + 20;
    m_ifid = '0;
    m_idex = '0;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    r = 0;
    cur = 0;
    @(posedge rst_n);
    while (r < rows.size()) begin
      @(negedge clk);
      d = ref_decode(m_ifid);
      exp_stall = (m_idex.exc_op == pipe_ctrl_pkg::EXC_LOAD) &&
                  ((d.rs1_idx != 5'd0 && d.rs1_idx == m_idex.rd_idx) ||
                   (d.rs2_idx != 5'd0 && d.rs2_idx == m_idex.rd_idx));
      checks += 2;
      assert (id_ex === m_idex) else begin
        errors++;
        $display("FAILED at %0t ns: id_ex_o %h, expected %h", $time, id_ex, m_idex);
      end
      assert (stall === exp_stall) else begin
        errors++;
        $display("FAILED at %0t ns: stall_o %b, expected %b", $time, stall, exp_stall);
      end
      // fetch holds its row while the stage stalls
      if (stall !== 1'b1) begin
        cur = r;
        r++;
      end
      apply_row(cur);
      d.rs1_data = operand(d.rs1_idx);
      d.rs2_data = operand(d.rs2_idx);
      if (exp_stall) begin
        m_idex = '0;
      end else begin
        m_idex = d;
        m_ifid = fetch;
      end
      if (wb.we && wb.addr != 5'd0) m_regs[wb.addr] = wb.data;
    end
    $display("decode stage checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

endmodule

//--- testbench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_PERIOD = 5,
  parameter int RST_CYCLES  = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // release on a falling edge, away from the flop sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
  parameter pipe_ctrl_pkg::fetch_t IF_ID_BUBBLE = '0,
  parameter pipe_ctrl_pkg::id_ex_t ID_EX_BUBBLE = '0
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  pipe_ctrl_pkg::fetch_t       fetch_i,
  input  pipe_ctrl_pkg::wb_t          wb_i,
  input  logic [rv_isa_pkg::XLEN-1:0] ex_result_i,
  input  pipe_ctrl_pkg::fwd_t         mem_fwd_i,
  output pipe_ctrl_pkg::id_ex_t       id_ex_o,
  output logic                        stall_o
);

  pipe_ctrl_pkg::fetch_t             if_id;
  pipe_ctrl_pkg::id_ex_t             decoded;
  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_idx;
  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_idx;
  logic [rv_isa_pkg::XLEN-1:0]       rs1_data;
  logic [rv_isa_pkg::XLEN-1:0]       rs2_data;
  logic                              load_use;

  // held while the load-use stall is up
  pipe_reg #(
    .payload_t (pipe_ctrl_pkg::fetch_t),
    .BUBBLE    (IF_ID_BUBBLE)
  ) u_if_id (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .hold_i   (load_use),
    .bubble_i (1'b0),
    .d_i      (fetch_i),
    .q_o      (if_id)
  );

  gpr_file u_gpr (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .wb_i       (wb_i),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  // execute bypass comes from the instruction now in ID/EX
  idu u_idu (
    .if_id_i       (if_id),
    .rs1_idx_o     (rs1_idx),
    .rs2_idx_o     (rs2_idx),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .prev_exc_op_i (id_ex_o.exc_op),
    .ex_rd_addr_i  (id_ex_o.rd_idx),
    .ex_rd_data_i  (ex_result_i),
    .mem_fwd_i     (mem_fwd_i),
    .decoded_o     (decoded),
    .load_use_o    (load_use)
  );

  // stalled slot goes out as a bubble
  pipe_reg #(
    .payload_t (pipe_ctrl_pkg::id_ex_t),
    .BUBBLE    (ID_EX_BUBBLE)
  ) u_id_ex (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .hold_i   (1'b0),
    .bubble_i (load_use),
    .d_i      (decoded),
    .q_o      (id_ex_o)
  );

  assign stall_o = load_use;

endmodule

//--- verilog/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
  parameter type      payload_t = logic,
  parameter payload_t BUBBLE    = '0
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     hold_i,
  input  logic     bubble_i,
  input  payload_t d_i,
  output payload_t q_o
);

  // bubble wins over hold
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      q_o <= BUBBLE;
    end else if (bubble_i) begin
      q_o <= BUBBLE;
    end else if (!hold_i) begin
      q_o <= d_i;
    end
  end

endmodule

//--- verilog/idu.sv
`timescale 1ns/1ps

module idu (
  input  pipe_ctrl_pkg::fetch_t             if_id_i,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_idx_o,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_idx_o,
  input  logic [rv_isa_pkg::XLEN-1:0]       rs1_data_i,
  input  logic [rv_isa_pkg::XLEN-1:0]       rs2_data_i,
  input  pipe_ctrl_pkg::exc_op_e            prev_exc_op_i,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] ex_rd_addr_i,
  input  logic [rv_isa_pkg::XLEN-1:0]       ex_rd_data_i,
  input  pipe_ctrl_pkg::fwd_t               mem_fwd_i,
  output pipe_ctrl_pkg::id_ex_t             decoded_o,
  output logic                              load_use_o
);

  localparam logic [31:0] M_OP = rv_isa_pkg::MASK_OPCODE;
  localparam logic [31:0] M_F3 = rv_isa_pkg::MASK_FUNC3;
  localparam logic [31:0] M_F7 = rv_isa_pkg::MASK_FUNC7;
  localparam logic [6:0]  BASE = rv_isa_pkg::F7_BASE;
  localparam logic [6:0]  ALT  = rv_isa_pkg::F7_ALT;

  function automatic logic match(input logic [31:0] word, input logic [31:0] mask,
                                 input logic [6:0] f7, input logic [2:0] f3,
                                 input logic [6:0] opc);
    return (word & mask) == ({f7, 10'b0, f3, 5'b0, opc} & mask);
  endfunction

  logic [31:0] inst;
  logic is_lui, is_auipc, is_jal, is_jalr;
  logic is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu;
  logic is_lb, is_lh, is_lw, is_lbu, is_lhu, is_sb, is_sh, is_sw;
  logic is_addi, is_slti, is_sltiu, is_xori, is_ori, is_andi;
  logic is_slli, is_srli, is_srai;
  logic is_add, is_sub, is_sll, is_slt, is_sltu, is_xor, is_srl, is_sra, is_or, is_and;
  logic is_ecall, is_ebreak, is_mret;
  logic t_branch, t_load, t_store, t_opimm, t_op, t_sys;
  logic r_type, i_type, s_type, b_type, u_type, j_type, illegal;
  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_idx, rs2_idx, rd_idx;
  logic [rv_isa_pkg::XLEN-1:0] imm, rs1_data, rs2_data;
  logic rs1_ex, rs2_ex, rs1_mem, rs2_mem;
  pipe_ctrl_pkg::alu_op_e alu_op;
  pipe_ctrl_pkg::mem_op_e mem_op;
  pipe_ctrl_pkg::exc_op_e exc_op;
  rv_isa_pkg::trap_t trap;

  assign inst = if_id_i.inst;

  assign is_lui   = match(inst, M_OP, BASE, 3'd0, rv_isa_pkg::OPC_LUI);
  assign is_auipc = match(inst, M_OP, BASE, 3'd0, rv_isa_pkg::OPC_AUIPC);
  assign is_jal   = match(inst, M_OP, BASE, 3'd0, rv_isa_pkg::OPC_JAL);
  assign is_jalr  = match(inst, M_F3, BASE, rv_isa_pkg::F3_JALR, rv_isa_pkg::OPC_JALR);

  assign is_beq  = match(inst, M_F3, BASE, rv_isa_pkg::F3_BEQ, rv_isa_pkg::OPC_BRANCH);
  assign is_bne  = match(inst, M_F3, BASE, rv_isa_pkg::F3_BNE, rv_isa_pkg::OPC_BRANCH);
  assign is_blt  = match(inst, M_F3, BASE, rv_isa_pkg::F3_BLT, rv_isa_pkg::OPC_BRANCH);
  assign is_bge  = match(inst, M_F3, BASE, rv_isa_pkg::F3_BGE, rv_isa_pkg::OPC_BRANCH);
  assign is_bltu = match(inst, M_F3, BASE, rv_isa_pkg::F3_BLTU, rv_isa_pkg::OPC_BRANCH);
  assign is_bgeu = match(inst, M_F3, BASE, rv_isa_pkg::F3_BGEU, rv_isa_pkg::OPC_BRANCH);

  assign is_lb  = match(inst, M_F3, BASE, rv_isa_pkg::F3_B, rv_isa_pkg::OPC_LOAD);
  assign is_lh  = match(inst, M_F3, BASE, rv_isa_pkg::F3_H, rv_isa_pkg::OPC_LOAD);
  assign is_lw  = match(inst, M_F3, BASE, rv_isa_pkg::F3_W, rv_isa_pkg::OPC_LOAD);
  assign is_lbu = match(inst, M_F3, BASE, rv_isa_pkg::F3_BU, rv_isa_pkg::OPC_LOAD);
  assign is_lhu = match(inst, M_F3, BASE, rv_isa_pkg::F3_HU, rv_isa_pkg::OPC_LOAD);
  assign is_sb  = match(inst, M_F3, BASE, rv_isa_pkg::F3_B, rv_isa_pkg::OPC_STORE);
  assign is_sh  = match(inst, M_F3, BASE, rv_isa_pkg::F3_H, rv_isa_pkg::OPC_STORE);
  assign is_sw  = match(inst, M_F3, BASE, rv_isa_pkg::F3_W, rv_isa_pkg::OPC_STORE);

  assign is_addi  = match(inst, M_F3, BASE, rv_isa_pkg::F3_ADD, rv_isa_pkg::OPC_OP_IMM);
  assign is_slti  = match(inst, M_F3, BASE, rv_isa_pkg::F3_SLT, rv_isa_pkg::OPC_OP_IMM);
  assign is_sltiu = match(inst, M_F3, BASE, rv_isa_pkg::F3_SLTU, rv_isa_pkg::OPC_OP_IMM);
  assign is_xori  = match(inst, M_F3, BASE, rv_isa_pkg::F3_XOR, rv_isa_pkg::OPC_OP_IMM);
  assign is_ori   = match(inst, M_F3, BASE, rv_isa_pkg::F3_OR, rv_isa_pkg::OPC_OP_IMM);
  assign is_andi  = match(inst, M_F3, BASE, rv_isa_pkg::F3_AND, rv_isa_pkg::OPC_OP_IMM);
  // shift immediates also check funct7
  assign is_slli  = match(inst, M_F7, BASE, rv_isa_pkg::F3_SLL, rv_isa_pkg::OPC_OP_IMM);
  assign is_srli  = match(inst, M_F7, BASE, rv_isa_pkg::F3_SR, rv_isa_pkg::OPC_OP_IMM);
  assign is_srai  = match(inst, M_F7, ALT, rv_isa_pkg::F3_SR, rv_isa_pkg::OPC_OP_IMM);

  assign is_add  = match(inst, M_F7, BASE, rv_isa_pkg::F3_ADD, rv_isa_pkg::OPC_OP);
  assign is_sub  = match(inst, M_F7, ALT, rv_isa_pkg::F3_ADD, rv_isa_pkg::OPC_OP);
  assign is_sll  = match(inst, M_F7, BASE, rv_isa_pkg::F3_SLL, rv_isa_pkg::OPC_OP);
  assign is_slt  = match(inst, M_F7, BASE, rv_isa_pkg::F3_SLT, rv_isa_pkg::OPC_OP);
  assign is_sltu = match(inst, M_F7, BASE, rv_isa_pkg::F3_SLTU, rv_isa_pkg::OPC_OP);
  assign is_xor  = match(inst, M_F7, BASE, rv_isa_pkg::F3_XOR, rv_isa_pkg::OPC_OP);
  assign is_srl  = match(inst, M_F7, BASE, rv_isa_pkg::F3_SR, rv_isa_pkg::OPC_OP);
  assign is_sra  = match(inst, M_F7, ALT, rv_isa_pkg::F3_SR, rv_isa_pkg::OPC_OP);
  assign is_or   = match(inst, M_F7, BASE, rv_isa_pkg::F3_OR, rv_isa_pkg::OPC_OP);
  assign is_and  = match(inst, M_F7, BASE, rv_isa_pkg::F3_AND, rv_isa_pkg::OPC_OP);

  assign is_ecall  = (inst == rv_isa_pkg::ECALL_WORD);
  assign is_ebreak = (inst == rv_isa_pkg::EBREAK_WORD);
  assign is_mret   = (inst == rv_isa_pkg::MRET_WORD);

  assign t_branch = is_beq | is_bne | is_blt | is_bge | is_bltu | is_bgeu;
  assign t_load   = is_lb | is_lh | is_lw | is_lbu | is_lhu;
  assign t_store  = is_sb | is_sh | is_sw;
  assign t_opimm  = is_addi | is_slti | is_sltiu | is_xori | is_ori | is_andi |
                    is_slli | is_srli | is_srai;
  assign t_op     = is_add | is_sub | is_sll | is_slt | is_sltu | is_xor |
                    is_srl | is_sra | is_or | is_and;
  assign t_sys    = is_ecall | is_ebreak | is_mret;

  assign r_type  = t_op;
  assign i_type  = t_load | t_opimm | is_jalr | t_sys;
  assign s_type  = t_store;
  assign b_type  = t_branch;
  assign u_type  = is_lui | is_auipc;
  assign j_type  = is_jal;
  assign illegal = ~(r_type | i_type | s_type | b_type | u_type | j_type);

  // unused fields read as x0
  assign rs1_idx = (r_type | i_type | s_type | b_type) ? inst[19:15] : '0;
  assign rs2_idx = (r_type | s_type | b_type) ? inst[24:20] : '0;
  assign rd_idx  = (r_type | i_type | u_type | j_type) ? inst[11:7] : '0;

  assign rs1_idx_o = rs1_idx;
  assign rs2_idx_o = rs2_idx;

  always_comb begin
    if (i_type) begin
      imm = {{21{inst[31]}}, inst[30:20]};
    end else if (s_type) begin
      imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
    end else if (b_type) begin
      imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    end else if (u_type) begin
      imm = {inst[31:12], 12'b0};
    end else if (j_type) begin
      imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    end else begin
      imm = '0;
    end
  end

  // ex beats mem, register file handles wb
  assign rs1_ex  = (rs1_idx != '0) && (rs1_idx == ex_rd_addr_i);
  assign rs2_ex  = (rs2_idx != '0) && (rs2_idx == ex_rd_addr_i);
  assign rs1_mem = (rs1_idx != '0) && (rs1_idx == mem_fwd_i.addr);
  assign rs2_mem = (rs2_idx != '0) && (rs2_idx == mem_fwd_i.addr);

  assign rs1_data = rs1_ex ? ex_rd_data_i : rs1_mem ? mem_fwd_i.data : rs1_data_i;
  assign rs2_data = rs2_ex ? ex_rd_data_i : rs2_mem ? mem_fwd_i.data : rs2_data_i;

  // load data not ready until mem stage
  assign load_use_o = if_id_i.valid && (prev_exc_op_i == pipe_ctrl_pkg::EXC_LOAD) &&
                      (rs1_ex || rs2_ex);

  always_comb begin
    alu_op = pipe_ctrl_pkg::ALU_NONE;
    if (is_add | is_addi | t_load | t_store | is_jal | is_jalr | u_type) begin
      alu_op = pipe_ctrl_pkg::ALU_ADD;
    end
    if (is_sub) alu_op = pipe_ctrl_pkg::ALU_SUB;
    if (is_xor | is_xori) alu_op = pipe_ctrl_pkg::ALU_XOR;
    if (is_or | is_ori) alu_op = pipe_ctrl_pkg::ALU_OR;
    if (is_and | is_andi) alu_op = pipe_ctrl_pkg::ALU_AND;
    if (is_sll | is_slli) alu_op = pipe_ctrl_pkg::ALU_SLL;
    if (is_srl | is_srli) alu_op = pipe_ctrl_pkg::ALU_SRL;
    if (is_sra | is_srai) alu_op = pipe_ctrl_pkg::ALU_SRA;
    if (is_slt | is_slti) alu_op = pipe_ctrl_pkg::ALU_SLT;
    if (is_sltu | is_sltiu) alu_op = pipe_ctrl_pkg::ALU_SLTU;
    if (is_beq) alu_op = pipe_ctrl_pkg::ALU_BEQ;
    if (is_bne) alu_op = pipe_ctrl_pkg::ALU_BNE;
    if (is_blt) alu_op = pipe_ctrl_pkg::ALU_BLT;
    if (is_bge) alu_op = pipe_ctrl_pkg::ALU_BGE;
    if (is_bltu) alu_op = pipe_ctrl_pkg::ALU_BLTU;
    if (is_bgeu) alu_op = pipe_ctrl_pkg::ALU_BGEU;
  end

  always_comb begin
    mem_op = pipe_ctrl_pkg::MEM_NONE;
    if (is_lb) mem_op = pipe_ctrl_pkg::MEM_LB;
    if (is_lbu) mem_op = pipe_ctrl_pkg::MEM_LBU;
    if (is_lh) mem_op = pipe_ctrl_pkg::MEM_LH;
    if (is_lhu) mem_op = pipe_ctrl_pkg::MEM_LHU;
    if (is_lw) mem_op = pipe_ctrl_pkg::MEM_LW;
    if (is_sb) mem_op = pipe_ctrl_pkg::MEM_SB;
    if (is_sh) mem_op = pipe_ctrl_pkg::MEM_SH;
    if (is_sw) mem_op = pipe_ctrl_pkg::MEM_SW;
  end

  // ecall and mret only leave trap bits
  always_comb begin
    exc_op = pipe_ctrl_pkg::EXC_NONE;
    if (is_lui) exc_op = pipe_ctrl_pkg::EXC_LUI;
    if (is_auipc) exc_op = pipe_ctrl_pkg::EXC_AUIPC;
    if (is_jal) exc_op = pipe_ctrl_pkg::EXC_JAL;
    if (is_jalr) exc_op = pipe_ctrl_pkg::EXC_JALR;
    if (t_load) exc_op = pipe_ctrl_pkg::EXC_LOAD;
    if (t_store) exc_op = pipe_ctrl_pkg::EXC_STORE;
    if (t_branch) exc_op = pipe_ctrl_pkg::EXC_BRANCH;
    if (t_opimm) exc_op = pipe_ctrl_pkg::EXC_OPIMM;
    if (t_op) exc_op = pipe_ctrl_pkg::EXC_OPREG;
    if (is_ebreak) exc_op = pipe_ctrl_pkg::EXC_EBREAK;
  end

  always_comb begin
    trap              = if_id_i.trap;
    trap.illegal_inst = illegal;
    trap.ecall        = is_ecall;
    trap.ebreak       = is_ebreak;
    trap.mret         = is_mret;
  end

  // invalid slot leaves an all-zero bubble
  always_comb begin
    decoded_o = '0;
    if (if_id_i.valid) begin
      decoded_o.valid    = 1'b1;
      decoded_o.addr     = if_id_i.addr;
      decoded_o.inst     = inst;
      decoded_o.rs1_idx  = rs1_idx;
      decoded_o.rs2_idx  = rs2_idx;
      decoded_o.rd_idx   = rd_idx;
      decoded_o.rs1_data = rs1_data;
      decoded_o.rs2_data = rs2_data;
      decoded_o.imm      = imm;
      decoded_o.alu_op   = alu_op;
      decoded_o.mem_op   = mem_op;
      decoded_o.exc_op   = exc_op;
      decoded_o.pc_op    = '0;
      decoded_o.trap     = trap;
    end
  end

endmodule

//--- verilog/gpr_file.sv
`timescale 1ns/1ps

module gpr_file (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_idx_i,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_idx_i,
  input  pipe_ctrl_pkg::wb_t                wb_i,
  output logic [rv_isa_pkg::XLEN-1:0]       rs1_data_o,
  output logic [rv_isa_pkg::XLEN-1:0]       rs2_data_o
);

  // x0 has no storage
  logic [rv_isa_pkg::XLEN-1:0] regs [1:31];
  logic                        wr_en;
  logic                        rs1_wt;
  logic                        rs2_wt;

  assign wr_en = wb_i.we && (wb_i.addr != '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb_i.addr] <= wb_i.data;
    end
  end

  // write-through, lowest bypass level
  assign rs1_wt = wr_en && (wb_i.addr == rs1_idx_i);
  assign rs2_wt = wr_en && (wb_i.addr == rs2_idx_i);

  assign rs1_data_o = (rs1_idx_i == '0) ? '0 :
                      rs1_wt            ? wb_i.data :
                                          regs[rs1_idx_i];
  assign rs2_data_o = (rs2_idx_i == '0) ? '0 :
                      rs2_wt            ? wb_i.data :
                                          regs[rs2_idx_i];

endmodule

//--- verilog/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

  typedef enum logic [4:0] {
    ALU_NONE,
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU,
    ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
  } alu_op_e;

  typedef enum logic [3:0] {
    MEM_NONE,
    MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW,
    MEM_SB, MEM_SH, MEM_SW
  } mem_op_e;

  typedef enum logic [3:0] {
    EXC_NONE,
    EXC_LUI, EXC_AUIPC, EXC_JAL, EXC_JALR,
    EXC_LOAD, EXC_STORE, EXC_BRANCH,
    EXC_OPIMM, EXC_OPREG, EXC_EBREAK
  } exc_op_e;

  // no redirect logic yet, always zero
  typedef logic [1:0] pc_op_t;

  typedef struct packed {
    logic                        valid;
    logic [rv_isa_pkg::XLEN-1:0] addr;
    logic [rv_isa_pkg::XLEN-1:0] inst;
    rv_isa_pkg::trap_t           trap;
  } fetch_t;

  typedef struct packed {
    logic                              we;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] addr;
    logic [rv_isa_pkg::XLEN-1:0]       data;
  } wb_t;

  // addr zero means nothing to forward
  typedef struct packed {
    logic [rv_isa_pkg::REG_ADDR_W-1:0] addr;
    logic [rv_isa_pkg::XLEN-1:0]       data;
  } fwd_t;

  typedef struct packed {
    logic                              valid;
    logic [rv_isa_pkg::XLEN-1:0]       addr;
    logic [rv_isa_pkg::XLEN-1:0]       inst;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_idx;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_idx;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd_idx;
    logic [rv_isa_pkg::XLEN-1:0]       rs1_data;
    logic [rv_isa_pkg::XLEN-1:0]       rs2_data;
    logic [rv_isa_pkg::XLEN-1:0]       imm;
    alu_op_e                           alu_op;
    mem_op_e                           mem_op;
    exc_op_e                           exc_op;
    pc_op_t                            pc_op;
    rv_isa_pkg::trap_t                 trap;
  } id_ex_t;

endpackage

//--- verilog/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // arithmetic and logic funct3
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;
  localparam logic [2:0] F3_JALR = 3'b000;

  // branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // load and store width
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  // funct7, ALT selects sub and sra
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  localparam logic [31:0] MASK_OPCODE = 32'h0000_007f;
  localparam logic [31:0] MASK_FUNC3  = 32'h0000_707f;
  localparam logic [31:0] MASK_FUNC7  = 32'hfe00_707f;

  localparam logic [31:0] ECALL_WORD  = {12'h000, 13'h0, OPC_SYSTEM};
  localparam logic [31:0] EBREAK_WORD = {12'h001, 13'h0, OPC_SYSTEM};
  localparam logic [31:0] MRET_WORD   = {12'h302, 13'h0, OPC_SYSTEM};

  // first field is the msb
  typedef struct packed {
    logic inst_misaligned;
    logic inst_access_fault;
    logic illegal_inst;
    logic ecall;
    logic ebreak;
    logic mret;
  } trap_t;

endpackage
